/* hdl/nib_types_pkg.sv */
`default_nettype none

package nib_types_pkg;

  localparam int NIBBLE_W = 4;
  localparam int INSTR_W  = 12;
  localparam int PC_W     = 8;
  localparam int RAM_AW   = 4;   // X and Y are nibbles

  typedef logic [NIBBLE_W-1:0] nibble_t;
  typedef logic [INSTR_W-1:0]  instr_t;
  typedef logic [PC_W-1:0]     pc_t;
  typedef logic [RAM_AW-1:0]   ram_addr_t;

endpackage

`default_nettype wire

/* hdl/nib_isa_pkg.sv */
`default_nettype none

package nib_isa_pkg;

  // Top nibble of the instruction word
  localparam logic [3:0] OPC_JMP     = 4'h1;
  localparam logic [3:0] OPC_SKIP    = 4'h2;
  localparam logic [3:0] OPC_ALU_REG = 4'hA;
  localparam logic [3:0] OPC_PTR     = 4'hC;
  localparam logic [3:0] OPC_ALU_IMM = 4'hD;

  // Function nibble of the register ALU format
  localparam logic [3:0] FN_ADD = 4'h0;
  localparam logic [3:0] FN_SUB = 4'h1;
  localparam logic [3:0] FN_AND = 4'h2;
  localparam logic [3:0] FN_OR  = 4'h3;
  localparam logic [3:0] FN_MOV = 4'h8;
  localparam logic [3:0] FN_XOR = 4'hE;

  // Upper three bits of the second nibble for pointer and skip words
  localparam logic [2:0] SUB_LD  = 3'b000;
  localparam logic [2:0] SUB_INC = 3'b001;

  localparam int INSTR_CYCLES = 7;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    MOV
  } alu_op_e;

  typedef enum logic [1:0] {
    A  = 2'd0,
    B  = 2'd1,
    MX = 2'd2,   // RAM at X
    MY = 2'd3    // RAM at Y
  } opnd_e;

  typedef enum logic [2:0] {
    ALU_REG,
    ALU_IMM,
    LD_PTR,
    INC_PTR,
    JMP,
    SKIP,
    NOP
  } instr_class_e;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    READ_DST,
    READ_SRC,
    EXEC,
    WRITE,
    ADVANCE
  } seq_state_e;

endpackage

`default_nettype wire

/* hdl/decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
  import nib_types_pkg::*;
  import nib_isa_pkg::*;

  instr_class_e cls;
  alu_op_e      op;
  opnd_e        dst;
  opnd_e        src;
  nibble_t      imm;
  logic         ptr_sel;    // 0 X, 1 Y
  logic         cond_sel;   // 0 zero, 1 carry
  pc_t          target;

  modport source (
    output cls, op, dst, src, imm, ptr_sel, cond_sel, target
  );

  modport sink (
    input cls, op, dst, src, imm, ptr_sel, cond_sel, target
  );

endinterface

`default_nettype wire

/* hdl/alu_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface alu_if;
  import nib_types_pkg::*;
  import nib_isa_pkg::*;

  alu_op_e op;
  nibble_t a;
  nibble_t b;
  logic    carry_in;
  nibble_t result;
  logic    carry_out;
  logic    zero;

  modport driver (
    output op, a, b, carry_in,
    input  result, carry_out, zero
  );

  modport alu (
    input  op, a, b, carry_in,
    output result, carry_out, zero
  );

endinterface

`default_nettype wire

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  nib_types_pkg::instr_t ir,
  decode_if.source              dec
);
  import nib_types_pkg::*;
  import nib_isa_pkg::*;

  nibble_t opc;
  nibble_t mid;
  nibble_t low;

  assign opc = ir[11:8];
  assign mid = ir[7:4];
  assign low = ir[3:0];

  always_comb begin
    dec.cls      = NOP;
    dec.op       = MOV;
    dec.dst      = A;
    dec.src      = A;
    dec.imm      = low;
    dec.ptr_sel  = mid[0];
    dec.cond_sel = mid[0];
    dec.target   = pc_t'(ir[7:0]);

    case (opc)
      OPC_ALU_REG: begin
        dec.cls = ALU_REG;
        dec.dst = opnd_e'(low[3:2]);
        dec.src = opnd_e'(low[1:0]);
        case (mid)
          FN_ADD:  dec.op = ADD;
          FN_SUB:  dec.op = SUB;
          FN_AND:  dec.op = AND;
          FN_OR:   dec.op = OR;
          FN_MOV:  dec.op = MOV;
          FN_XOR:  dec.op = XOR;
          default: dec.cls = NOP;   // Unused function codes
        endcase
      end
      OPC_ALU_IMM: begin
        dec.cls = ALU_IMM;
        dec.dst = opnd_e'(mid[1:0]);
        dec.src = opnd_e'(mid[1:0]);   // Keeps ram_addr on the destination
        case (mid[3:2])
          2'b00:   dec.op = XOR;
          2'b01:   dec.op = ADD;
          2'b10:   dec.op = AND;
          default: dec.op = MOV;
        endcase
      end
      OPC_PTR: begin
        if (mid[3:1] == SUB_LD) begin
          dec.cls = LD_PTR;
        end else if (mid[3:1] == SUB_INC && low == 4'h0) begin
          dec.cls = INC_PTR;
        end
      end
      OPC_JMP: dec.cls = JMP;
      OPC_SKIP: begin
        if (mid[3:1] == SUB_LD && low == 4'h0) begin
          dec.cls = SKIP;
        end
      end
      default: dec.cls = NOP;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  alu_if.alu p
);
  import nib_types_pkg::*;
  import nib_isa_pkg::*;

  logic [NIBBLE_W:0] wide;   // Result with carry or borrow on top

  always_comb begin
    wide        = '0;
    p.result    = p.b;
    p.carry_out = p.carry_in;   // Logic ops and MOV leave carry alone

    case (p.op)
      ADD: begin
        wide        = {1'b0, p.a} + {1'b0, p.b};
        p.result    = wide[NIBBLE_W-1:0];
        p.carry_out = wide[NIBBLE_W];
      end
      SUB: begin
        wide        = {1'b0, p.a} - {1'b0, p.b};
        p.result    = wide[NIBBLE_W-1:0];
        p.carry_out = wide[NIBBLE_W];   // Set when a < b
      end
      AND: p.result = p.a & p.b;
      OR:  p.result = p.a | p.b;
      XOR: p.result = p.a ^ p.b;
      default: p.result = p.b;
    endcase
  end

  assign p.zero = (p.result == '0);

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                     clk,
  input  logic                     rst_n,
  input  nib_isa_pkg::seq_state_e  state,
  decode_if.sink                   dec,
  alu_if.driver                    alu_p,
  output nib_types_pkg::ram_addr_t ram_addr,
  output nib_types_pkg::nibble_t   ram_wdata,
  output logic                     ram_we,
  input  nib_types_pkg::nibble_t   ram_rdata,
  output logic                     zero_flag,
  output logic                     carry_flag
);
  import nib_types_pkg::*;
  import nib_isa_pkg::*;

  nibble_t   a;
  nibble_t   b;
  ram_addr_t x;
  ram_addr_t y;
  nibble_t   dst_val;
  nibble_t   src_val;
  nibble_t   res;
  logic      res_c;
  logic      res_z;
  logic      is_alu;
  opnd_e     addr_sel;

  function automatic nibble_t read_opnd(opnd_e sel);
    case (sel)
      A:       return a;
      B:       return b;
      default: return ram_rdata;   // ram_addr already points at X or Y
    endcase
  endfunction

  assign is_alu   = (dec.cls == ALU_REG) || (dec.cls == ALU_IMM);
  assign addr_sel = (state == READ_SRC) ? dec.src : dec.dst;
  assign ram_addr = (addr_sel == MY) ? y : x;

  assign alu_p.op       = dec.op;
  assign alu_p.a        = dst_val;
  assign alu_p.b        = src_val;
  assign alu_p.carry_in = carry_flag;

  assign ram_wdata = res;
  assign ram_we    = (state == WRITE) && is_alu && (dec.dst == MX || dec.dst == MY);

  // Operand and result latches
  always_ff @(posedge clk) begin
    case (state)
      READ_DST: dst_val <= read_opnd(dec.dst);
      READ_SRC: src_val <= (dec.cls == ALU_IMM) ? dec.imm : read_opnd(dec.src);
      EXEC: begin
        res   <= alu_p.result;
        res_c <= alu_p.carry_out;
        res_z <= alu_p.zero;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a          <= '0;
      b          <= '0;
      x          <= '0;
      y          <= '0;
      zero_flag  <= 1'b0;
      carry_flag <= 1'b0;
    end else if (state == WRITE) begin
      if (is_alu) begin
        case (dec.dst)
          A:       a <= res;
          B:       b <= res;
          default: ;   // Memory destination goes out through ram_we
        endcase
        if (dec.op != MOV) begin
          zero_flag  <= res_z;
          carry_flag <= res_c;
        end
      end
      if (dec.cls == LD_PTR) begin
        if (dec.ptr_sel) y <= dec.imm;
        else             x <= dec.imm;
      end
      if (dec.cls == INC_PTR) begin
        if (dec.ptr_sel) y <= y + ram_addr_t'(1);   // Wraps at 15
        else             x <= x + ram_addr_t'(1);
      end
    end
  end

  // One-cycle write pulse
  we_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    ram_we |=> !ram_we);

endmodule

`default_nettype wire

/* hdl/sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  output nib_types_pkg::pc_t      rom_addr,
  input  nib_types_pkg::instr_t   rom_data,
  output nib_types_pkg::instr_t   ir,
  decode_if.sink                  dec,
  output nib_isa_pkg::seq_state_e state,
  input  logic                    zero_flag,
  input  logic                    carry_flag
);
  import nib_types_pkg::*;
  import nib_isa_pkg::*;

  seq_state_e state_nxt;
  pc_t        pc;
  logic       skip_taken;

  assign rom_addr   = pc;
  assign skip_taken = (dec.cls == SKIP) && (dec.cond_sel ? carry_flag : zero_flag);

  always_comb begin
    case (state)
      FETCH:    state_nxt = DECODE;
      DECODE:   state_nxt = READ_DST;
      READ_DST: state_nxt = READ_SRC;
      READ_SRC: state_nxt = EXEC;
      EXEC:     state_nxt = WRITE;
      WRITE:    state_nxt = ADVANCE;
      default:  state_nxt = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= FETCH;
      pc    <= '0;
    end else begin
      state <= state_nxt;
      if (state == ADVANCE) begin
        if (dec.cls == JMP)  pc <= dec.target;
        else if (skip_taken) pc <= pc + pc_t'(2);
        else                 pc <= pc + pc_t'(1);
      end
    end
  end

  // Instruction register, held until the next FETCH
  always_ff @(posedge clk) begin
    if (state == FETCH) ir <= rom_data;
  end

  // Decoded fields hold from DECODE to the next FETCH
  dec_held: assert property (@(posedge clk) disable iff (!rst_n)
    state != FETCH |=> $stable(dec.cls) && $stable(dec.target));

  // Skip decisions see flags that only move in WRITE
  flags_held: assert property (@(posedge clk) disable iff (!rst_n)
    state != WRITE |=> $stable(zero_flag) && $stable(carry_flag));

endmodule

`default_nettype wire

/* hdl/nib_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module nib_cpu (
  input  logic                     clk,
  input  logic                     rst_n,
  output nib_types_pkg::pc_t       rom_addr,
  input  nib_types_pkg::instr_t    rom_data,
  output nib_types_pkg::ram_addr_t ram_addr,
  output nib_types_pkg::nibble_t   ram_wdata,
  output logic                     ram_we,
  input  nib_types_pkg::nibble_t   ram_rdata
);
  import nib_types_pkg::*;
  import nib_isa_pkg::*;

  instr_t     ir;
  seq_state_e state;
  logic       zero_flag;
  logic       carry_flag;

  decode_if dec_bus ();
  alu_if    alu_bus ();

  sequencer seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .ir         (ir),
    .dec        (dec_bus.sink),
    .state      (state),
    .zero_flag  (zero_flag),
    .carry_flag (carry_flag)
  );

  instr_decoder dcd (
    .ir  (ir),
    .dec (dec_bus.source)
  );

  reg_file regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .dec        (dec_bus.sink),
    .alu_p      (alu_bus.driver),
    .ram_addr   (ram_addr),
    .ram_wdata  (ram_wdata),
    .ram_we     (ram_we),
    .ram_rdata  (ram_rdata),
    .zero_flag  (zero_flag),
    .carry_flag (carry_flag)
  );

  alu alu_u (
    .p (alu_bus.alu)
  );

endmodule

`default_nettype wire

/* sim/nib_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module nib_cpu_tb;
  import nib_types_pkg::*;

  localparam int INSTR_LEN    = 7;
  localparam int WRITE_CYCLE  = 5;   // Counted from FETCH
  localparam int PROG_LEN     = 200;
  localparam int RESET_CYCLES = 5;
  localparam int TIMEOUT      = PROG_LEN * INSTR_LEN * 2 + RESET_CYCLES;
  localparam int unsigned SEED = 53091;

  logic      clk = 1'b0;
  logic      rst_n;
  pc_t       rom_addr;
  instr_t    rom_data;
  ram_addr_t ram_addr;
  nibble_t   ram_wdata;
  logic      ram_we;
  nibble_t   ram_rdata;

  instr_t  rom [256];
  nibble_t mem [16];   // RAM as the DUT sees it

  // Reference ISA model
  nibble_t m_a;
  nibble_t m_b;
  nibble_t m_x;
  nibble_t m_y;
  logic    m_z;
  logic    m_c;
  pc_t     m_pc;
  nibble_t m_ram [16];

  int unsigned lcg_state;
  int errors;
  int cycle_count = 0;
  int n_instr;
  int n_jumps;
  int n_skip_taken;
  int n_skip_not;
  int n_writes;

  nib_cpu dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we),
    .ram_rdata (ram_rdata)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout: program did not reach its end within %0d cycles", TIMEOUT);
      $display("Errors: %0d", errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return lcg_next() % n;
  endfunction

  function automatic nibble_t rand_nibble();
    return nibble_t'(lcg_next());
  endfunction

  task automatic build_program();
    int unsigned pick;
    int unsigned target;
    nibble_t     fn;
    nibble_t     n1;
    nibble_t     n2;
    logic        b1;
    logic        b2;
    for (int i = 0; i < 256; i++) begin
      rom[i] = 12'h000;   // NOP past the program
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      pick = rand_below(100);
      n1 = rand_nibble();
      n2 = rand_nibble();
      b1 = 1'(lcg_next());
      b2 = 1'(lcg_next());
      case (rand_below(6))
        0: fn = 4'h0;
        1: fn = 4'h1;
        2: fn = 4'h2;
        3: fn = 4'h3;
        4: fn = 4'h8;
        default: fn = 4'hE;
      endcase
      if (pick < 28) begin
        rom[i] = {4'hA, fn, n1};
      end else if (pick < 38) begin
        rom[i] = {4'hA, 4'h8, 1'b1, b1, 1'b0, b2};   // Store A or B to [X] or [Y]
      end else if (pick < 56) begin
        rom[i] = {4'hD, n1, n2};
      end else if (pick < 64) begin
        rom[i] = {4'hC, 3'b000, b1, n1};
      end else if (pick < 70) begin
        rom[i] = {4'hC, 3'b001, b1, 4'h0};
      end else if (pick < 82) begin
        rom[i] = {4'h2, 3'b000, b1, 4'h0};
      end else if (pick < 90) begin
        target = i + 2 + rand_below(4);
        if (target > PROG_LEN) target = PROG_LEN;
        rom[i] = {4'h1, 8'(target)};
      end else begin
        case (rand_below(3))
          0: rom[i] = {4'h0, n1, n2};
          1: rom[i] = {4'hA, 4'h5, n1};   // Unused function code
          default: rom[i] = {4'h2, 4'h1, 4'h7};
        endcase
      end
    end
  endtask

  task automatic fill_ram();
    for (int i = 0; i < 16; i++) begin
      mem[i]   = rand_nibble();
      m_ram[i] = mem[i];
    end
  endtask

  function automatic nibble_t opnd_value(input logic [1:0] sel);
    case (sel)
      2'd0: return m_a;
      2'd1: return m_b;
      2'd2: return m_ram[m_x];
      default: return m_ram[m_y];
    endcase
  endfunction

  // op is 0 ADD, 1 SUB, 2 AND, 3 OR, 4 XOR, 5 MOV
  task automatic model_alu(input int op, input logic [1:0] dsel, input nibble_t s,
                           output bit we, output ram_addr_t addr, output nibble_t data);
    int      d;
    int      sum;
    nibble_t r;
    d = int'(opnd_value(dsel));
    case (op)
      0: begin
        sum = d + int'(s);
        r   = nibble_t'(sum);
        m_c = (sum > 15);
      end
      1: begin
        sum = d - int'(s);
        r   = nibble_t'(sum);
        m_c = (d < int'(s));   // Borrow
      end
      2: r = nibble_t'(d) & s;
      3: r = nibble_t'(d) | s;
      4: r = nibble_t'(d) ^ s;
      default: r = s;
    endcase
    if (op != 5) m_z = (r == 4'h0);
    data = r;
    case (dsel)
      2'd0: m_a = r;
      2'd1: m_b = r;
      2'd2: begin
        we   = 1'b1;
        addr = m_x;
        m_ram[m_x] = r;
      end
      default: begin
        we   = 1'b1;
        addr = m_y;
        m_ram[m_y] = r;
      end
    endcase
  endtask

  task automatic model_step(input instr_t w, output bit we, output ram_addr_t addr,
                            output nibble_t data);
    nibble_t hi;
    nibble_t mid;
    nibble_t lo;
    int      op;
    logic    cond;
    pc_t     next_pc;
    hi = w[11:8];
    mid = w[7:4];
    lo = w[3:0];
    we = 1'b0;
    addr = '0;
    data = '0;
    next_pc = m_pc + 8'd1;
    case (hi)
      4'hA: begin
        case (mid)
          4'h0: op = 0;
          4'h1: op = 1;
          4'h2: op = 2;
          4'h3: op = 3;
          4'h8: op = 5;
          4'hE: op = 4;
          default: op = -1;
        endcase
        if (op >= 0) model_alu(op, lo[3:2], opnd_value(lo[1:0]), we, addr, data);
      end
      4'hD: begin
        case (mid[3:2])
          2'b00: op = 4;
          2'b01: op = 0;
          2'b10: op = 2;
          default: op = 5;
        endcase
        model_alu(op, mid[1:0], lo, we, addr, data);
      end
      4'hC: begin
        if (mid[3:1] == 3'b000) begin
          if (mid[0]) m_y = lo;
          else m_x = lo;
        end else if (mid[3:1] == 3'b001 && lo == 4'h0) begin
          if (mid[0]) m_y = m_y + 4'd1;
          else m_x = m_x + 4'd1;
        end
      end
      4'h1: begin
        next_pc = w[7:0];
        n_jumps++;
      end
      4'h2: begin
        if (mid[3:1] == 3'b000 && lo == 4'h0) begin
          cond = mid[0] ? m_c : m_z;
          if (cond) begin
            next_pc = m_pc + 8'd2;
            n_skip_taken++;
          end else begin
            n_skip_not++;
          end
        end
      end
      default: ;
    endcase
    m_pc = next_pc;
  endtask

  // Memories answer on the falling edge
  task automatic next_cycle();
    @(negedge clk);
    if (ram_we) mem[ram_addr] = ram_wdata;
    rom_data  = rom[rom_addr];
    ram_rdata = mem[ram_addr];
  endtask

  task automatic run_instruction(output bit stop);
    pc_t       start_pc;
    bit        exp_we;
    ram_addr_t exp_addr;
    nibble_t   exp_data;
    bit        seen_we;
    int        cycles;
    start_pc = m_pc;
    stop = 1'b0;
    seen_we = 1'b0;
    cycles = 0;
    model_step(rom[start_pc], exp_we, exp_addr, exp_data);
    n_instr++;
    do begin
      next_cycle();
      cycles++;
      if (ram_we) begin
        if (cycles != WRITE_CYCLE) begin
          errors++;
          $display("Error: ram_we = 0x%h in cycle %0d at pc 0x%h, expected 0x0",
                   ram_we, cycles, start_pc);
        end else if (!exp_we) begin
          errors++;
          $display("Error: ram_we = 0x%h for instruction 0x%h at pc 0x%h, expected 0x0",
                   ram_we, rom[start_pc], start_pc);
        end else begin
          seen_we = 1'b1;
          n_writes++;
          if (ram_addr !== exp_addr) begin
            errors++;
            $display("Error: ram_addr = 0x%h, expected 0x%h (pc 0x%h)",
                     ram_addr, exp_addr, start_pc);
          end
          if (ram_wdata !== exp_data) begin
            errors++;
            $display("Error: ram_wdata = 0x%h, expected 0x%h (pc 0x%h)",
                     ram_wdata, exp_data, start_pc);
          end
        end
      end
    end while (rom_addr == start_pc && cycles < 2 * INSTR_LEN);
    if (exp_we && !seen_we) begin
      errors++;
      $display("Missing RAM write for instruction 0x%h at pc 0x%h", rom[start_pc], start_pc);
    end
    if (rom_addr == start_pc) begin
      errors++;
      $display("rom_addr stuck at 0x%h for %0d cycles", start_pc, cycles);
      stop = 1'b1;
    end else if (cycles != INSTR_LEN) begin
      errors++;
      $display("rom_addr changed after %0d cycles instead of %0d", cycles, INSTR_LEN);
      stop = 1'b1;
    end else if (rom_addr !== m_pc) begin
      errors++;
      $display("Error: rom_addr = 0x%h, expected 0x%h", rom_addr, m_pc);
      stop = 1'b1;
    end else if (int'(m_pc) >= PROG_LEN) begin
      stop = 1'b1;
    end
  endtask

  task automatic compare_ram();
    for (int i = 0; i < 16; i++) begin
      if (mem[i] !== m_ram[i]) begin
        errors++;
        $display("Error: ram[%0d] = 0x%h, expected 0x%h", i, mem[i], m_ram[i]);
      end
    end
  endtask

  initial begin
    bit stop;
    rst_n = 1'b0;
    rom_data = '0;
    ram_rdata = '0;
    errors = 0;
    n_instr = 0;
    n_jumps = 0;
    n_skip_taken = 0;
    n_skip_not = 0;
    n_writes = 0;
    lcg_state = SEED;
    m_a = '0;
    m_b = '0;
    m_x = '0;
    m_y = '0;
    m_z = 1'b0;
    m_c = 1'b0;
    m_pc = '0;
    build_program();
    fill_ram();

    repeat (RESET_CYCLES) begin
      next_cycle();
      if (ram_we) begin
        errors++;
        $display("Error: ram_we = 0x%h during reset, expected 0x0", ram_we);
      end
    end
    rst_n = 1'b1;
    if (rom_addr !== 8'h00) begin
      errors++;
      $display("Error: rom_addr = 0x%h after reset, expected 0x00", rom_addr);
    end

    stop = 1'b0;
    while (!stop) run_instruction(stop);
    compare_ram();

    if (n_jumps == 0 || n_skip_taken == 0 || n_skip_not == 0 || n_writes == 0) begin
      errors++;
      $display("Program missed a jump, a taken or untaken skip, or a RAM write");
    end

    $display("Ran %0d instructions, %0d jumps, %0d skips taken, %0d not taken, %0d writes",
             n_instr, n_jumps, n_skip_taken, n_skip_not, n_writes);
    $display("Errors: %0d", errors);
    if (errors == 0) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/nib_types_pkg.sv
hdl/nib_isa_pkg.sv
hdl/decode_if.sv
hdl/alu_if.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/sequencer.sv
hdl/nib_cpu.sv
sim/nib_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the nib_cpu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module nib_cpu_tb \
  -f src.f --Mdir obj_dir -o nib_cpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/nib_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
exit 0
